// File: mob_adder_tree.sv
`timescale 1ns/100ps
`default_nettype none

module mob_adder_tree (
   input  wire                 clk,
   input  mob_pkg::eval_pair_t terms [mob_pkg::NUM_SQUARES],
   output mob_pkg::eval_pair_t sum
);

   import mob_pkg::*;

   eval_pair_t stage1 [NUM_SQUARES/4];    // 16 partial sums
   eval_pair_t stage2 [NUM_SQUARES/16];   // 4 partial sums

   // mg and eg reduce independently
   function automatic eval_pair_t sum4(
      input eval_pair_t a,
      input eval_pair_t b,
      input eval_pair_t c,
      input eval_pair_t d
   );
      eval_pair_t s;

      s.mg = a.mg + b.mg + c.mg + d.mg;
      s.eg = a.eg + b.eg + c.eg + d.eg;
      return s;
   endfunction

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < NUM_SQUARES/4; i++)
         stage1[i] <= sum4(terms[4*i], terms[4*i+1], terms[4*i+2], terms[4*i+3]);
      for (int i = 0; i < NUM_SQUARES/16; i++)
         stage2[i] <= sum4(stage1[4*i], stage1[4*i+1], stage1[4*i+2], stage1[4*i+3]);
      sum <= sum4(stage2[0], stage2[1], stage2[2], stage2[3]);
   end

endmodule

`default_nettype wire

// File: mob_control.sv
`timescale 1ns/100ps
`default_nettype none

module mob_control (
   input  wire  clk,
   input  wire  reset,
   input  wire  board_valid,
   input  wire  clear_eval,
   output logic board_load,
   output logic eval_valid
);

   import mob_pkg::*;

   typedef enum logic [1:0] {
      s_idle,
      s_latency,
      s_wait_clear
   } state_t;

   state_t state;
   logic board_valid_r;
   logic [LAT_WIDTH-1:0] lat_count;

   // Rising edge of board_valid, only taken while idle
   assign board_load = (state == s_idle) && board_valid && !board_valid_r;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= s_idle;
         board_valid_r <= 1'b0;
         lat_count <= '0;
         eval_valid <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;
         case (state)
            s_idle:
               if (board_load)
               begin
                  state <= s_latency;
                  lat_count <= LAT_WIDTH'(1);
               end
            s_latency:
            begin
               lat_count <= lat_count + 1'b1;
               if (lat_count == LAT_WIDTH'(LATENCY))   // Tree output settled
               begin
                  eval_valid <= 1'b1;
                  state <= s_wait_clear;
               end
            end
            s_wait_clear:
               if (clear_eval)
               begin
                  eval_valid <= 1'b0;
                  state <= s_idle;
               end
            default:
               state <= s_idle;
         endcase
      end
   end

   load_pulse: assert property (@(posedge clk) disable iff (reset)
      board_load |=> !board_load);

   valid_release: assert property (@(posedge clk) disable iff (reset)
      $fell(eval_valid) |-> $past(clear_eval));

endmodule

`default_nettype wire

// File: mob_eval_top.f
+incdir+.
mob_pkg.sv
mob_square.sv
mob_adder_tree.sv
mob_control.sv
mob_eval_top.sv
tb_mob_eval_top.sv

// File: mob_eval_top.sv
`timescale 1ns/100ps
`default_nettype none

module mob_eval_top (
   input  wire                            clk,
   input  wire                            reset,
   input  wire [mob_pkg::BOARD_WIDTH-1:0] board,
   input  wire                            board_valid,
   input  wire                            clear_eval,
   output mob_pkg::eval_pair_t            eval,
   output logic                           eval_valid
);

   import mob_pkg::*;

   logic board_load;
   logic [BOARD_WIDTH-1:0] board_r;
   eval_pair_t square_score [NUM_SQUARES];

   always_ff @(posedge clk)
   begin
      if (board_load)
         board_r <= board;
   end

   mob_control u_control (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .board_load  (board_load),
      .eval_valid  (eval_valid)
   );

   for (genvar row = 0; row < BOARD_SIZE; row++)
   begin : g_row
      for (genvar col = 0; col < BOARD_SIZE; col++)
      begin : g_col
         mob_square #(
            .ROW (row),
            .COL (col)
         ) u_square (
            .clk   (clk),
            .board (board_r),
            .score (square_score[row*BOARD_SIZE+col])
         );
      end
   end

   mob_adder_tree u_tree (
      .clk   (clk),
      .terms (square_score),
      .sum   (eval)
   );

   // Result held while waiting for clear, board_r frozen by the control
   eval_hold: assert property (@(posedge clk) disable iff (reset)
      eval_valid |=> !eval_valid || $stable(eval));

endmodule

`default_nettype wire

// File: mob_pkg.sv
`default_nettype none

package mob_pkg;

   // Board geometry
   localparam int BOARD_SIZE = 8;
   localparam int NUM_SQUARES = BOARD_SIZE * BOARD_SIZE;
   localparam int PIECE_WIDTH = 4;
   localparam int BOARD_WIDTH = NUM_SQUARES * PIECE_WIDTH;   // 256

   // Piece code layout, bit 3 set for black
   localparam int COLOR_BIT = 3;
   localparam int KIND_WIDTH = 3;

   localparam logic [KIND_WIDTH-1:0] KIND_EMPTY  = 3'd0;
   localparam logic [KIND_WIDTH-1:0] KIND_PAWN   = 3'd1;
   localparam logic [KIND_WIDTH-1:0] KIND_KNIGHT = 3'd2;
   localparam logic [KIND_WIDTH-1:0] KIND_BISHOP = 3'd3;
   localparam logic [KIND_WIDTH-1:0] KIND_ROOK   = 3'd4;
   localparam logic [KIND_WIDTH-1:0] KIND_QUEEN  = 3'd5;
   localparam logic [KIND_WIDTH-1:0] KIND_KING   = 3'd6;

   // Score and count widths
   localparam int EVAL_WIDTH = 16;
   localparam int COUNT_WIDTH = 4;
   localparam int MAX_MOBILITY = 14;   // Rook on an empty board

   // Linear weight per reachable square
   localparam int MOB_MG_KNIGHT = 4;
   localparam int MOB_EG_KNIGHT = 4;
   localparam int MOB_MG_BISHOP = 5;
   localparam int MOB_EG_BISHOP = 3;
   localparam int MOB_MG_ROOK = 2;
   localparam int MOB_EG_ROOK = 6;

   // Clocks from board load to eval_valid
   localparam int LATENCY = 4;
   localparam int LAT_WIDTH = $clog2(LATENCY + 1);

   typedef struct packed {
      logic signed [EVAL_WIDTH-1:0] mg;
      logic signed [EVAL_WIDTH-1:0] eg;
   } eval_pair_t;

endpackage

`default_nettype wire

// File: mob_square.sv
`timescale 1ns/100ps
`default_nettype none

module mob_square #(
   parameter int ROW = 0,
   parameter int COL = 0
) (
   input  wire                            clk,
   input  wire [mob_pkg::BOARD_WIDTH-1:0] board,
   output mob_pkg::eval_pair_t            score
);

   import mob_pkg::*;

   logic [PIECE_WIDTH-1:0] piece;
   logic [KIND_WIDTH-1:0] kind;
   logic color;
   logic [COUNT_WIDTH-1:0] count;
   logic [EVAL_WIDTH-1:0] w_mg;
   logic [EVAL_WIDTH-1:0] w_eg;
   logic [EVAL_WIDTH-1:0] mg_mag;
   logic [EVAL_WIDTH-1:0] eg_mag;

   function automatic logic [PIECE_WIDTH-1:0] piece_at(
      input logic [BOARD_WIDTH-1:0] b,
      input int r,
      input int c
   );
      return b[PIECE_WIDTH*(r*BOARD_SIZE+c) +: PIECE_WIDTH];
   endfunction

   assign piece = piece_at(board, ROW, COL);
   assign kind = piece[KIND_WIDTH-1:0];
   assign color = piece[COLOR_BIT];

   always_comb
   begin
      int r;
      int c;
      logic blocked;
      logic [PIECE_WIDTH-1:0] target;

      count = '0;
      r = 0;
      c = 0;
      blocked = 1'b0;
      target = '0;
      if (kind == KIND_KNIGHT)
      begin
         // Offsets with dr^2 + dc^2 == 5 are the eight knight jumps
         for (int dr = -2; dr <= 2; dr++)
            for (int dc = -2; dc <= 2; dc++)
            begin
               r = ROW + dr;
               c = COL + dc;
               if (dr*dr + dc*dc == 5 && r >= 0 && r < BOARD_SIZE && c >= 0 && c < BOARD_SIZE)
               begin
                  target = piece_at(board, r, c);
                  if (target[KIND_WIDTH-1:0] == KIND_EMPTY || target[COLOR_BIT] != color)
                     count = count + 1'b1;
               end
            end
      end
      else if (kind == KIND_BISHOP || kind == KIND_ROOK)
      begin
         for (int dr = -1; dr <= 1; dr++)
            for (int dc = -1; dc <= 1; dc++)
               if ((kind == KIND_BISHOP && dr != 0 && dc != 0) ||
                   (kind == KIND_ROOK && ((dr == 0) != (dc == 0))))
               begin
                  blocked = 1'b0;
                  for (int k = 1; k < BOARD_SIZE; k++)
                  begin
                     r = ROW + dr*k;
                     c = COL + dc*k;
                     if (!blocked && r >= 0 && r < BOARD_SIZE && c >= 0 && c < BOARD_SIZE)
                     begin
                        target = piece_at(board, r, c);
                        if (target[KIND_WIDTH-1:0] == KIND_EMPTY)
                           count = count + 1'b1;
                        else
                        begin
                           blocked = 1'b1;
                           if (target[COLOR_BIT] != color)   // Capture counts
                              count = count + 1'b1;
                        end
                     end
                  end
               end
      end
   end

   always_comb
   begin
      case (kind)
         KIND_KNIGHT:
         begin
            w_mg = EVAL_WIDTH'(MOB_MG_KNIGHT);
            w_eg = EVAL_WIDTH'(MOB_EG_KNIGHT);
         end
         KIND_BISHOP:
         begin
            w_mg = EVAL_WIDTH'(MOB_MG_BISHOP);
            w_eg = EVAL_WIDTH'(MOB_EG_BISHOP);
         end
         KIND_ROOK:
         begin
            w_mg = EVAL_WIDTH'(MOB_MG_ROOK);
            w_eg = EVAL_WIDTH'(MOB_EG_ROOK);
         end
         default:
         begin
            w_mg = '0;
            w_eg = '0;
         end
      endcase
   end

   assign mg_mag = EVAL_WIDTH'(count) * w_mg;
   assign eg_mag = EVAL_WIDTH'(count) * w_eg;

   // Black subtracts
   always_ff @(posedge clk)
   begin
      score.mg <= color ? -$signed(mg_mag) : $signed(mg_mag);
      score.eg <= color ? -$signed(eg_mag) : $signed(eg_mag);
   end

   count_max: assert property (@(posedge clk) count <= COUNT_WIDTH'(MAX_MOBILITY));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the mobility evaluator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   -f mob_eval_top.f \
   --top-module tb_mob_eval_top \
   -o tb_mob_eval_top
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_mob_eval_top
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi
exit 0

// File: tb_mob_model.svh
`ifndef TB_MOB_MODEL_SVH
`define TB_MOB_MODEL_SVH

function automatic eval_pair_t make_pair(input int mg, input int eg);
   eval_pair_t p;

   p.mg = EVAL_WIDTH'(mg);
   p.eg = EVAL_WIDTH'(eg);
   return p;
endfunction

function automatic logic [PIECE_WIDTH-1:0] model_piece(
   input logic [BOARD_WIDTH-1:0] b,
   input int row,
   input int col
);
   return b[(row*BOARD_SIZE + col)*PIECE_WIDTH +: PIECE_WIDTH];
endfunction

// Squares reached stepping (dr, dc), a capture ends the ray and counts
function automatic int model_ray(
   input logic [BOARD_WIDTH-1:0] b,
   input int row,
   input int col,
   input logic black,
   input int dr,
   input int dc,
   input int max_steps
);
   int r;
   int c;
   int n;
   logic [PIECE_WIDTH-1:0] p;

   n = 0;
   for (int step = 1; step <= max_steps; step++)
   begin
      r = row + dr*step;
      c = col + dc*step;
      if (r < 0 || r >= BOARD_SIZE || c < 0 || c >= BOARD_SIZE)
         return n;
      p = model_piece(b, r, c);
      if (p[KIND_WIDTH-1:0] != KIND_EMPTY)
         return (p[COLOR_BIT] != black) ? n + 1 : n;
      n++;
   end
   return n;
endfunction

function automatic int model_reach(input logic [BOARD_WIDTH-1:0] b, input int sq);
   int jump_r [8];
   int jump_c [8];
   int row;
   int col;
   int n;
   logic [PIECE_WIDTH-1:0] p;

   jump_r = '{1, 2, 2, 1, -1, -2, -2, -1};
   jump_c = '{2, 1, -1, -2, -2, -1, 1, 2};
   row = sq / BOARD_SIZE;
   col = sq % BOARD_SIZE;
   p = model_piece(b, row, col);
   n = 0;
   case (p[KIND_WIDTH-1:0])
      KIND_KNIGHT:   // A jump is a ray of one step
         for (int j = 0; j < 8; j++)
            n += model_ray(b, row, col, p[COLOR_BIT], jump_r[j], jump_c[j], 1);
      KIND_BISHOP:
         for (int j = 0; j < 4; j++)
            n += model_ray(b, row, col, p[COLOR_BIT], j[1] ? 1 : -1, j[0] ? 1 : -1,
                           BOARD_SIZE - 1);
      KIND_ROOK:
         for (int j = 0; j < 4; j++)
            n += model_ray(b, row, col, p[COLOR_BIT], (j == 0) ? 1 : (j == 1) ? -1 : 0,
                           (j == 2) ? 1 : (j == 3) ? -1 : 0, BOARD_SIZE - 1);
      default:
         n = 0;
   endcase
   return n;
endfunction

function automatic eval_pair_t model_eval(input logic [BOARD_WIDTH-1:0] b);
   int mg;
   int eg;
   int n;
   int sign;
   logic [PIECE_WIDTH-1:0] p;

   mg = 0;
   eg = 0;
   for (int sq = 0; sq < NUM_SQUARES; sq++)
   begin
      p = b[sq*PIECE_WIDTH +: PIECE_WIDTH];
      n = model_reach(b, sq);
      sign = p[COLOR_BIT] ? -1 : 1;   // Black subtracts
      if (p[KIND_WIDTH-1:0] == KIND_KNIGHT)
      begin
         mg += sign * n * MOB_MG_KNIGHT;
         eg += sign * n * MOB_EG_KNIGHT;
      end
      else if (p[KIND_WIDTH-1:0] == KIND_BISHOP)
      begin
         mg += sign * n * MOB_MG_BISHOP;
         eg += sign * n * MOB_EG_BISHOP;
      end
      else if (p[KIND_WIDTH-1:0] == KIND_ROOK)
      begin
         mg += sign * n * MOB_MG_ROOK;
         eg += sign * n * MOB_EG_ROOK;
      end
   end
   return make_pair(mg, eg);
endfunction

`endif

// File: tb_mob_eval_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mob_eval_top;

   import mob_pkg::*;

   localparam int NUM_RANDOM = 200;
   localparam int NUM_BOARDS = NUM_RANDOM + 4;
   localparam int WATCHDOG_CYCLES = NUM_BOARDS * (LATENCY + 8) + 100;

   logic clk = 1'b0;
   logic reset;
   logic [BOARD_WIDTH-1:0] board;
   logic board_valid;
   logic clear_eval;
   eval_pair_t eval;
   logic eval_valid;
   logic [31:0] rng_state;
   logic [BOARD_WIDTH-1:0] test_board;
   logic [BOARD_WIDTH-1:0] other_board;
   eval_pair_t expected;

   `include "tb_mob_model.svh"

   mob_eval_top UUT (
      .clk         (clk),
      .reset       (reset),
      .board       (board),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .eval        (eval),
      .eval_valid  (eval_valid)
   );

   always #10 clk = ~clk;

   task automatic abort_run();
      $display(">>> FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_pair(input string name, input eval_pair_t got, input eval_pair_t exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s mg=%h eg=%h expected mg=%h eg=%h",
                  name, got.mg, got.eg, exp.mg, exp.eg);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s got=%h expected=%h", name, got, exp);
         abort_run();
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;

      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic random_board(output logic [BOARD_WIDTH-1:0] b);
      int kind;

      b = '0;
      for (int sq = 0; sq < NUM_SQUARES; sq++)
      begin
         rng_state = xorshift32(rng_state);
         kind = 1 + int'(rng_state[15:8]) % 6;
         if (rng_state[0])   // Roughly half the squares occupied
            b[sq*PIECE_WIDTH +: PIECE_WIDTH] = {rng_state[1], KIND_WIDTH'(kind)};
      end
   endtask

   // Rising strobe from idle, eval_valid due LATENCY edges after the load edge
   task automatic evaluate(input logic [BOARD_WIDTH-1:0] b, input eval_pair_t exp);
      board = b;
      board_valid = 1'b1;
      for (int k = 0; k <= LATENCY; k++)
      begin
         @(posedge clk);
         #1;
         check_bit("eval_valid", eval_valid, k == LATENCY);
      end
      check_pair("eval", eval, exp);
   endtask

   task automatic release_eval();
      clear_eval = 1'b1;
      board_valid = 1'b0;
      @(posedge clk);
      #1;
      clear_eval = 1'b0;
      check_bit("eval_valid", eval_valid, 1'b0);
   endtask

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired before the test sequence finished");
      abort_run();
   end

   initial
   begin
      rng_state = 32'hb168;
      reset = 1'b1;
      board = '0;
      board_valid = 1'b0;
      clear_eval = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      repeat (2)
      begin
         @(posedge clk);
         #1;
         check_bit("eval_valid", eval_valid, 1'b0);
      end

      test_board = '0;
      evaluate(test_board, make_pair(0, 0));
      release_eval();
      test_board[PIECE_WIDTH-1:0] = {1'b0, KIND_KNIGHT};   // Corner knight, two jumps
      evaluate(test_board, make_pair(8, 8));
      release_eval();
      test_board[PIECE_WIDTH-1:0] = {1'b1, KIND_ROOK};
      evaluate(test_board, make_pair(-28, -84));
      release_eval();

      // New strobe while the result is pending
      random_board(test_board);
      random_board(other_board);
      expected = model_eval(test_board);
      evaluate(test_board, expected);
      board_valid = 1'b0;
      @(posedge clk);
      #1;
      board = other_board;
      board_valid = 1'b1;
      repeat (LATENCY + 2)
      begin
         @(posedge clk);
         #1;
         check_bit("eval_valid", eval_valid, 1'b1);
         check_pair("eval", eval, expected);
      end
      release_eval();

      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         random_board(test_board);
         evaluate(test_board, model_eval(test_board));
         release_eval();
      end
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire
